// ==== compile.f ====
source/soc_pkg.sv
source/apb_access_fsm.sv
source/word_ram.sv
source/rtc_timer.sv
source/soc_mem_fabric.sv
verification/soc_mem_fabric_asserts.sv
verification/soc_mem_fabric_tb.sv

// ==== verification/soc_mem_fabric_tb.sv ====
// Testbench for the memory fabric with stimulus table, APB driver, compare tasks and timeout
`default_nettype none
`timescale 1ns/1ps

module soc_mem_fabric_tb;
   import soc_pkg::*;

   typedef enum logic [1:0] {
      CHK_NONE,    // Write transfer, read data not compared
      CHK_EXACT,
      CHK_MARK,    // Kept for a later ordering check
      CHK_ABOVE    // Must exceed the kept value
   } chk_e;

   logic  clk_i;
   logic  rst_ni;
   logic  psel_i;
   logic  penable_i;
   logic  pwrite_i;
   addr_t paddr_i;
   data_t pwdata_i;
   strb_t pstrb_i;
   data_t prdata_o;
   logic  pready_o;
   logic  pslverr_o;
   logic  timer_irq_o;

   // Stimulus table, one entry per transfer
   logic  tbl_write[$];
   addr_t tbl_addr[$];
   data_t tbl_wdata[$];
   strb_t tbl_strb[$];
   data_t tbl_rdata[$];
   chk_e  tbl_chk[$];
   logic  tbl_err[$];
   logic  tbl_irq[$];

   integer seed;
   int     cycle_count;
   int     cycle_limit;
   data_t  marked;

   soc_mem_fabric dut_i (
      .clk_i       ( clk_i       ),
      .rst_ni      ( rst_ni      ),
      .psel_i      ( psel_i      ),
      .penable_i   ( penable_i   ),
      .pwrite_i    ( pwrite_i    ),
      .paddr_i     ( paddr_i     ),
      .pwdata_i    ( pwdata_i    ),
      .pstrb_i     ( pstrb_i     ),
      .prdata_o    ( prdata_o    ),
      .pready_o    ( pready_o    ),
      .pslverr_o   ( pslverr_o   ),
      .timer_irq_o ( timer_irq_o )
   );

   always #10 clk_i = ~clk_i; // 20 ns period

   task automatic fail_now();
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   always @(posedge clk_i) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
         fail_now();
      end
   end

   task automatic check_data(input data_t got, input data_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
         fail_now();
      end
   endtask

   task automatic check_increase(input data_t got, input data_t floor, input string what);
      if (!(got > floor)) begin
         $display("FAILED at %0t: %s read %h, not above %h", $time, what, got, floor);
         fail_now();
      end
   endtask

   task automatic check_err(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s pslverr %b, expected %b", $time, what, got, exp);
         fail_now();
      end
   endtask

   task automatic check_irq(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s timer_irq %b, expected %b", $time, what, got, exp);
         fail_now();
      end
   endtask

   task automatic check_latency(input int got, input string what);
      if (got != 2) begin
         $display("FAILED at %0t: %s pready after %0d clocks, expected 2", $time, what, got);
         fail_now();
      end
   endtask

   // Byte lanes with a set strobe take the new data
   function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t s);
      data_t res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (s[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
      end
      return res;
   endfunction

   function automatic addr_t word_addr(input logic [7:0] region, input int word);
      addr_t a;
      a = {region, 24'h0} + (word * 4);
      return a;
   endfunction

   task automatic add_entry(input logic wr, input addr_t addr, input data_t wdata,
                            input strb_t strb, input data_t rdata, input chk_e chk,
                            input logic err, input logic irq);
      tbl_write.push_back(wr);
      tbl_addr.push_back(addr);
      tbl_wdata.push_back(wdata);
      tbl_strb.push_back(strb);
      tbl_rdata.push_back(rdata);
      tbl_chk.push_back(chk);
      tbl_err.push_back(err);
      tbl_irq.push_back(irq);
   endtask

   task automatic add_write(input addr_t addr, input data_t wdata, input strb_t strb,
                            input logic err, input logic irq);
      add_entry(1'b1, addr, wdata, strb, '0, CHK_NONE, err, irq);
   endtask

   task automatic add_read(input addr_t addr, input data_t exp, input chk_e chk,
                           input logic err, input logic irq);
      add_entry(1'b0, addr, '0, '0, exp, chk, err, irq);
   endtask

   task automatic build_table();
      data_t r [16];
      addr_t cmp_lo;
      addr_t cmp_hi;
      addr_t mt_lo;
      for (int i = 0; i < 16; i++) r[i] = $random(seed);
      cmp_lo = {TIMER_BASE, 24'h0} + TIMER_CMP_LO;
      cmp_hi = {TIMER_BASE, 24'h0} + TIMER_CMP_HI;
      mt_lo  = {TIMER_BASE, 24'h0} + TIMER_MTIME_LO;
      // Base and last word of every bank
      add_write(word_addr(BOOT_BASE, 0), r[0], 4'hF, 1'b0, 1'b0);
      add_write(word_addr(BOOT_BASE, BOOT_DEPTH - 1), r[1], 4'hF, 1'b0, 1'b0);
      add_read(word_addr(BOOT_BASE, 0), r[0], CHK_EXACT, 1'b0, 1'b0);
      add_read(word_addr(BOOT_BASE, BOOT_DEPTH - 1), r[1], CHK_EXACT, 1'b0, 1'b0);
      add_write(word_addr(SHARED_BASE, 0), r[2], 4'hF, 1'b0, 1'b0);
      add_write(word_addr(SHARED_BASE, SHARED_DEPTH - 1), r[3], 4'hF, 1'b0, 1'b0);
      add_read(word_addr(SHARED_BASE, 0), r[2], CHK_EXACT, 1'b0, 1'b0);
      add_read(word_addr(SHARED_BASE, SHARED_DEPTH - 1), r[3], CHK_EXACT, 1'b0, 1'b0);
      add_write(word_addr(MAIN_BASE, 0), r[4], 4'hF, 1'b0, 1'b0);
      add_write(word_addr(MAIN_BASE, MAIN_DEPTH - 1), r[5], 4'hF, 1'b0, 1'b0);
      add_read(word_addr(MAIN_BASE, 0), r[4], CHK_EXACT, 1'b0, 1'b0);
      add_read(word_addr(MAIN_BASE, MAIN_DEPTH - 1), r[5], CHK_EXACT, 1'b0, 1'b0);
      // Partial strobes merge with the old word
      add_write(word_addr(MAIN_BASE, 5), r[6], 4'hF, 1'b0, 1'b0);
      add_write(word_addr(MAIN_BASE, 5), r[7], 4'b0101, 1'b0, 1'b0);
      add_read(word_addr(MAIN_BASE, 5), merge_bytes(r[6], r[7], 4'b0101), CHK_EXACT, 1'b0, 1'b0);
      add_write(word_addr(BOOT_BASE, 3), r[8], 4'hF, 1'b0, 1'b0);
      add_write(word_addr(BOOT_BASE, 3), r[9], 4'b1000, 1'b0, 1'b0);
      add_read(word_addr(BOOT_BASE, 3), merge_bytes(r[8], r[9], 4'b1000), CHK_EXACT, 1'b0, 1'b0);
      // Index wraps at the bank depth
      add_write(word_addr(SHARED_BASE, SHARED_DEPTH), r[10], 4'hF, 1'b0, 1'b0);
      add_read(word_addr(SHARED_BASE, 0), r[10], CHK_EXACT, 1'b0, 1'b0);
      add_write(word_addr(BOOT_BASE, BOOT_DEPTH), r[11], 4'hF, 1'b0, 1'b0);
      add_read(word_addr(BOOT_BASE, 0), r[11], CHK_EXACT, 1'b0, 1'b0);
      // Unmapped region 60 hex, same word offset as boot word 2
      add_write(word_addr(BOOT_BASE, 2), r[12], 4'hF, 1'b0, 1'b0);
      add_read(word_addr(8'h60, 0), '0, CHK_NONE, 1'b1, 1'b0);
      add_write(word_addr(8'h60, 2), r[13], 4'hF, 1'b1, 1'b0);
      add_read(word_addr(BOOT_BASE, 2), r[12], CHK_EXACT, 1'b0, 1'b0);
      // Timer, irq lags a compare write by one cycle
      add_read(mt_lo, '0, CHK_MARK, 1'b0, 1'b0);
      add_read(mt_lo, '0, CHK_ABOVE, 1'b0, 1'b0);
      add_write(cmp_hi, 32'h0, 4'hF, 1'b0, 1'b0);
      add_write(cmp_lo, 32'h0, 4'hF, 1'b0, 1'b0);
      add_read(cmp_lo, 32'h0, CHK_EXACT, 1'b0, 1'b1);
      add_write(cmp_hi, '1, 4'hF, 1'b0, 1'b1);
      add_read(cmp_hi, '1, CHK_EXACT, 1'b0, 1'b0);
      add_write(cmp_lo, '1, 4'hF, 1'b0, 1'b0);
      add_read(cmp_lo, '1, CHK_EXACT, 1'b0, 1'b0);
   endtask

   // One APB transfer; lat counts clocks from the setup cycle to pready
   task automatic apb_transfer(input logic wr, input addr_t addr, input data_t wdata,
                               input strb_t strb, output data_t rdata, output logic err,
                               output logic irq, output int lat);
      psel_i    = 1'b1;   // Setup cycle
      penable_i = 1'b0;
      pwrite_i  = wr;
      paddr_i   = addr;
      pwdata_i  = wdata;
      pstrb_i   = strb;
      lat       = 0;
      @(posedge clk_i);
      #2;
      penable_i = 1'b1;
      lat       = 1;
      @(negedge clk_i);
      while (!pready_o) begin
         @(posedge clk_i);
         #2;
         lat = lat + 1;
         @(negedge clk_i);
      end
      rdata = prdata_o;   // Sampled mid-cycle
      err   = pslverr_o;
      irq   = timer_irq_o;
      @(posedge clk_i);
      #2;
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   initial begin
      data_t got;
      logic  err;
      logic  irq;
      int    lat;
      string what;
      clk_i       = 1'b0;
      rst_ni      = 1'b0;
      psel_i      = 1'b0;
      penable_i   = 1'b0;
      pwrite_i    = 1'b0;
      paddr_i     = '0;
      pwdata_i    = '0;
      pstrb_i     = '0;
      seed        = 32'h22ab9521;
      cycle_count = 0;
      marked      = '0;
      build_table();
      cycle_limit = tbl_addr.size() * 6 + 200;
      repeat (10) @(posedge clk_i);
      #2;
      rst_ni = 1'b1;
      @(negedge clk_i);
      check_irq(timer_irq_o, 1'b0, "after reset");
      @(posedge clk_i);
      #2;
      for (int i = 0; i < tbl_addr.size(); i++) begin
         what = $sformatf("entry %0d addr %h", i, tbl_addr[i]);
         apb_transfer(tbl_write[i], tbl_addr[i], tbl_wdata[i], tbl_strb[i], got, err, irq, lat);
         check_latency(lat, what);
         check_err(err, tbl_err[i], what);
         check_irq(irq, tbl_irq[i], what);
         case (tbl_chk[i])
            CHK_EXACT: check_data(got, tbl_rdata[i], what);
            CHK_MARK:  marked = got;
            CHK_ABOVE: check_increase(got, marked, what);
            default:   ;
         endcase
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/soc_mem_fabric_asserts.sv ====
// APB protocol and timing assertions bound to the access FSM
`default_nettype none
`timescale 1ns/1ps

module soc_mem_fabric_asserts (
   input wire                         clk_i,
   input wire                         rst_ni,
   input wire                         psel_i,
   input wire                         penable_i,
   input wire [soc_pkg::ADDR_W-1:0]   paddr_i,
   input wire                         pready_o,
   input wire                         pslverr_o,
   input wire                         boot_req_o,
   input wire                         shared_req_o,
   input wire                         main_req_o,
   input wire                         timer_req_o
);
   import soc_pkg::*;

   logic [7:0] region;
   logic       mapped;

   assign region = paddr_i[ADDR_W-1:ADDR_W-8];
   assign mapped = (region == BOOT_BASE) || (region == SHARED_BASE) ||
                   (region == TIMER_BASE) || (region == MAIN_BASE); // From the address map

   // pready only inside an access phase
   pready_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pready_o |-> (psel_i && penable_i))
      else $error("pready high outside an APB access phase");

   // Error response only for an unmapped region
   slverr_with_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pslverr_o |-> (pready_o && !mapped))
      else $error("pslverr high without pready or for a mapped address");

   // Exactly one wait state
   one_wait_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (psel_i && $rose(penable_i)) |-> !pready_o ##1 pready_o)
      else $error("pready did not follow the first access cycle by one clock");

   // One strobe in the first access cycle of a mapped transfer, none at other times
   single_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $countones({boot_req_o, shared_req_o, main_req_o, timer_req_o}) ==
         ((psel_i && $rose(penable_i) && mapped) ? 1 : 0))
      else $error("target request strobes do not match the transfer");

endmodule

bind apb_access_fsm soc_mem_fabric_asserts asserts_i (
   .clk_i        ( clk_i        ),
   .rst_ni       ( rst_ni       ),
   .psel_i       ( psel_i       ),
   .penable_i    ( penable_i    ),
   .paddr_i      ( paddr_i      ),
   .pready_o     ( pready_o     ),
   .pslverr_o    ( pslverr_o    ),
   .boot_req_o   ( boot_req_o   ),
   .shared_req_o ( shared_req_o ),
   .main_req_o   ( main_req_o   ),
   .timer_req_o  ( timer_req_o  )
);

`default_nettype wire

// ==== source/soc_mem_fabric.sv ====
// Memory fabric top with APB slave FSM, boot, shared and main RAM banks and timer
`default_nettype none
`timescale 1ns/1ps

module soc_mem_fabric (
   input  wire            clk_i,
   input  wire            rst_ni,
   input  wire            psel_i,
   input  wire            penable_i,
   input  wire            pwrite_i,
   input  soc_pkg::addr_t paddr_i,
   input  soc_pkg::data_t pwdata_i,
   input  soc_pkg::strb_t pstrb_i,
   output soc_pkg::data_t prdata_o,
   output logic           pready_o,
   output logic           pslverr_o,
   output logic           timer_irq_o
);
   import soc_pkg::*;

   // Shared request bus towards all targets
   logic      boot_req, shared_req, main_req, timer_req;
   logic      we;
   word_idx_t index;
   data_t     wdata;
   strb_t     wstrb;

   data_t     boot_rdata, shared_rdata, main_rdata, timer_rdata;

   apb_access_fsm apb_fsm_i (
      .clk_i          ( clk_i        ),
      .rst_ni         ( rst_ni       ),
      .psel_i         ( psel_i       ),
      .penable_i      ( penable_i    ),
      .pwrite_i       ( pwrite_i     ),
      .paddr_i        ( paddr_i      ),
      .pwdata_i       ( pwdata_i     ),
      .pstrb_i        ( pstrb_i      ),
      .boot_rdata_i   ( boot_rdata   ),
      .shared_rdata_i ( shared_rdata ),
      .main_rdata_i   ( main_rdata   ),
      .timer_rdata_i  ( timer_rdata  ),
      .prdata_o       ( prdata_o     ),
      .pready_o       ( pready_o     ),
      .pslverr_o      ( pslverr_o    ),
      .boot_req_o     ( boot_req     ),
      .shared_req_o   ( shared_req   ),
      .main_req_o     ( main_req     ),
      .timer_req_o    ( timer_req    ),
      .we_o           ( we           ),
      .index_o        ( index        ),
      .wdata_o        ( wdata        ),
      .wstrb_o        ( wstrb        )
   );

   // Boot memory at 4000_0000
   word_ram #(.DEPTH(BOOT_DEPTH)) boot_ram_i (
      .clk_i   ( clk_i      ),
      .rst_ni  ( rst_ni     ),
      .req_i   ( boot_req   ),
      .we_i    ( we         ),
      .index_i ( index      ),
      .wdata_i ( wdata      ),
      .wstrb_i ( wstrb      ),
      .rdata_o ( boot_rdata )
   );

   // Shared memory at 4200_0000
   word_ram #(.DEPTH(SHARED_DEPTH)) shared_ram_i (
      .clk_i   ( clk_i        ),
      .rst_ni  ( rst_ni       ),
      .req_i   ( shared_req   ),
      .we_i    ( we           ),
      .index_i ( index        ),
      .wdata_i ( wdata        ),
      .wstrb_i ( wstrb        ),
      .rdata_o ( shared_rdata )
   );

   // Main memory at 8000_0000
   word_ram #(.DEPTH(MAIN_DEPTH)) main_ram_i (
      .clk_i   ( clk_i      ),
      .rst_ni  ( rst_ni     ),
      .req_i   ( main_req   ),
      .we_i    ( we         ),
      .index_i ( index      ),
      .wdata_i ( wdata      ),
      .wstrb_i ( wstrb      ),
      .rdata_o ( main_rdata )
   );

   rtc_timer rtc_timer_i (
      .clk_i       ( clk_i       ),
      .rst_ni      ( rst_ni      ),
      .req_i       ( timer_req   ),
      .we_i        ( we          ),
      .index_i     ( index       ),
      .wdata_i     ( wdata       ),
      .rdata_o     ( timer_rdata ),
      .timer_irq_o ( timer_irq_o )
   );

endmodule

`default_nettype wire

// ==== source/rtc_timer.sv ====
// Real-time timer with 64-bit mtime, 64-bit mtimecmp and level timer interrupt
`default_nettype none
`timescale 1ns/1ps

module rtc_timer (
   input  wire                clk_i,
   input  wire                rst_ni,
   input  wire                req_i,
   input  wire                we_i,
   input  soc_pkg::word_idx_t index_i,
   input  soc_pkg::data_t     wdata_i,
   output soc_pkg::data_t     rdata_o,
   output logic               timer_irq_o
);
   import soc_pkg::*;

   logic [2*DATA_W-1:0] mtime_q;
   logic [2*DATA_W-1:0] mtimecmp_q;
   logic [3:0]          reg_off;
   data_t               rd_mux;
   data_t               rdata_q;
   logic                irq_q;

   // Byte offset of the selected register
   assign reg_off = {index_i[1:0], 2'b00};

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         mtime_q    <= '0;
         mtimecmp_q <= '1;   // Keeps the interrupt low out of reset
      end else begin
         mtime_q <= mtime_q + 64'd1;
         // Whole-register writes, strobes not used
         if (req_i && we_i) begin
            case (reg_off)
               TIMER_MTIME_LO: mtime_q[DATA_W-1:0]           <= wdata_i;
               TIMER_MTIME_HI: mtime_q[2*DATA_W-1:DATA_W]    <= wdata_i;
               TIMER_CMP_LO:   mtimecmp_q[DATA_W-1:0]        <= wdata_i;
               TIMER_CMP_HI:   mtimecmp_q[2*DATA_W-1:DATA_W] <= wdata_i;
               default:        ;
            endcase
         end
      end
   end

   always_comb begin
      case (reg_off)
         TIMER_MTIME_LO: rd_mux = mtime_q[DATA_W-1:0];
         TIMER_MTIME_HI: rd_mux = mtime_q[2*DATA_W-1:DATA_W];
         TIMER_CMP_LO:   rd_mux = mtimecmp_q[DATA_W-1:0];
         TIMER_CMP_HI:   rd_mux = mtimecmp_q[2*DATA_W-1:DATA_W];
         default:        rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rdata_q <= '0;
         irq_q   <= 1'b0;
      end else begin
         if (req_i && !we_i) rdata_q <= rd_mux;
         irq_q <= (mtime_q >= mtimecmp_q); // Level, one cycle behind the compare
      end
   end

   assign rdata_o     = rdata_q;
   assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

// ==== source/word_ram.sv ====
// Single-port word RAM with byte write strobes and a registered read port
`default_nettype none
`timescale 1ns/1ps

module word_ram #(
   parameter int unsigned DEPTH = 64
) (
   input  wire                clk_i,
   input  wire                rst_ni,
   input  wire                req_i,
   input  wire                we_i,
   input  soc_pkg::word_idx_t index_i,
   input  soc_pkg::data_t     wdata_i,
   input  soc_pkg::strb_t     wstrb_i,
   output soc_pkg::data_t     rdata_o
);
   import soc_pkg::*;

   localparam int unsigned IDX_W = $clog2(DEPTH);

   data_t             mem [DEPTH];
   logic  [IDX_W-1:0] addr;
   data_t             rdata_q;

   assign addr = index_i[IDX_W-1:0]; // Wraps modulo DEPTH

   always_ff @(posedge clk_i) begin
      if (req_i && we_i) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb_i[b]) mem[addr][b*8 +: 8] <= wdata_i[b*8 +: 8];
         end
      end
   end

   // Read word captured on the request edge
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rdata_q <= '0;
      end else if (req_i && !we_i) begin
         rdata_q <= mem[addr];
      end
   end

   assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== source/apb_access_fsm.sv ====
// APB transfer FSM with address decode, target request strobes and read-data select
`default_nettype none
`timescale 1ns/1ps

module apb_access_fsm (
   input  wire                clk_i,
   input  wire                rst_ni,
   input  wire                psel_i,
   input  wire                penable_i,
   input  wire                pwrite_i,
   input  soc_pkg::addr_t     paddr_i,
   input  soc_pkg::data_t     pwdata_i,
   input  soc_pkg::strb_t     pstrb_i,
   input  soc_pkg::data_t     boot_rdata_i,
   input  soc_pkg::data_t     shared_rdata_i,
   input  soc_pkg::data_t     main_rdata_i,
   input  soc_pkg::data_t     timer_rdata_i,
   output soc_pkg::data_t     prdata_o,
   output logic               pready_o,
   output logic               pslverr_o,
   output logic               boot_req_o,
   output logic               shared_req_o,
   output logic               main_req_o,
   output logic               timer_req_o,
   output logic               we_o,
   output soc_pkg::word_idx_t index_o,
   output soc_pkg::data_t     wdata_o,
   output soc_pkg::strb_t     wstrb_o
);
   import soc_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,    // First access cycle, target strobed here
      RESPOND    // Wait state done, pready high
   } state_e;

   state_e  state_q, state_d;
   target_e target_d, target_q;
   logic    access_start;

   // Region decode on the top address byte
   always_comb begin
      case (paddr_i[ADDR_W-1:ADDR_W-8])
         BOOT_BASE:   target_d = TGT_BOOT;
         SHARED_BASE: target_d = TGT_SHARED;
         TIMER_BASE:  target_d = TGT_TIMER;
         MAIN_BASE:   target_d = TGT_MAIN;
         default:     target_d = TGT_NONE;
      endcase
   end

   assign access_start = (state_q == ACCESS) && psel_i && penable_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:    if (psel_i && !penable_i) state_d = ACCESS; // Setup cycle seen
         ACCESS:  state_d = access_start ? RESPOND : IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q  <= IDLE;
         target_q <= TGT_NONE;
      end else begin
         state_q <= state_d;
         if (access_start) target_q <= target_d; // Held for the response cycle
      end
   end

   // One-cycle strobes towards the targets
   assign boot_req_o   = access_start && (target_d == TGT_BOOT);
   assign shared_req_o = access_start && (target_d == TGT_SHARED);
   assign timer_req_o  = access_start && (target_d == TGT_TIMER);
   assign main_req_o   = access_start && (target_d == TGT_MAIN);

   assign we_o    = access_start && pwrite_i;
   assign index_o = paddr_i[ADDR_W-1:2];
   assign wdata_o = pwdata_i;
   assign wstrb_o = pstrb_i;

   // Response side
   assign pready_o  = (state_q == RESPOND);
   assign pslverr_o = (state_q == RESPOND) && (target_q == TGT_NONE);

   always_comb begin
      case (target_q)
         TGT_BOOT:   prdata_o = boot_rdata_i;
         TGT_SHARED: prdata_o = shared_rdata_i;
         TGT_TIMER:  prdata_o = timer_rdata_i;
         TGT_MAIN:   prdata_o = main_rdata_i;
         default:    prdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== source/soc_pkg.sv ====
// Package with bus widths, word types, address map and timer register offsets
`default_nettype none

package soc_pkg;

   // APB bus widths
   localparam int unsigned ADDR_W = 32;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned STRB_W = DATA_W / 8; // One strobe per byte lane

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;

   // Word address, byte offset bits dropped
   typedef logic [ADDR_W-3:0] word_idx_t;

   // Region selectors, compared against the top address byte
   localparam logic [7:0] BOOT_BASE   = 8'h40;
   localparam logic [7:0] SHARED_BASE = 8'h42;
   localparam logic [7:0] TIMER_BASE  = 8'h44;
   localparam logic [7:0] MAIN_BASE   = 8'h80;

   // Bank sizes in words
   localparam int unsigned BOOT_DEPTH   = 256;
   localparam int unsigned SHARED_DEPTH = 64;
   localparam int unsigned MAIN_DEPTH   = 1024;

   // Decoded target of one transfer
   typedef enum logic [2:0] {
      TGT_BOOT,
      TGT_SHARED,
      TGT_TIMER,
      TGT_MAIN,
      TGT_NONE   // Unmapped, answers with pslverr
   } target_e;

   // Byte offsets inside the timer region
   localparam logic [3:0] TIMER_MTIME_LO = 4'h0;
   localparam logic [3:0] TIMER_MTIME_HI = 4'h4;
   localparam logic [3:0] TIMER_CMP_LO   = 4'h8;
   localparam logic [3:0] TIMER_CMP_HI   = 4'hC;

endpackage

`default_nettype wire
